//--- eth_rx_pkg.sv
// Ethernet receive path shared definitions
// frame constants, FIFO sizing and the enums used by the framer and the stats block

package eth_rx_pkg;

    // ------------------------------------------------------------------------
    // frame format
    // ------------------------------------------------------------------------
    localparam logic [3:0] preamble_nibble = 4'h5;   // 0x55 bytes seen as nibbles
    localparam logic [3:0] sfd_nibble      = 4'hd;   // upper half of 0xd5

    // frames shorter than this are runts
    localparam logic [15:0] min_frame_len = 16'd64;

    // width of the per-frame byte count
    localparam int frame_len_w = 16;

    // ------------------------------------------------------------------------
    // byte fifo sizing
    // ------------------------------------------------------------------------
    localparam int fifo_depth  = 16;
    localparam int fifo_addr_w = 4;    // log2 of fifo_depth

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------
    // framer FSM
    typedef enum logic [1:0] {
        st_idle,        // line quiet, waiting for dv
        st_preamble,    // counting 5 nibbles until the delimiter
        st_data,        // pairing nibbles into bytes
        st_drop         // bad preamble, wait for dv to drop
    } framer_state_e;

    // per-frame result, error wins over runt
    typedef enum logic [1:0] {
        fs_good,
        fs_rx_error,
        fs_runt
    } frame_status_e;

endpackage

//--- rgmii_rx_conv.sv
// RGMII receive to MII conversion
// captures rx_ctl on both clock edges and registers the nibble twice

`timescale 1ns/1ps

module rgmii_rx_conv (
    input  logic       net_phy_rx_clk,
    input  logic       rgmii_phy_rst_n,
    input  logic       rgmii_phy_rxctl,   // dv on rise, dv ^ er on fall
    input  logic [3:0] rgmii_phy_rxd,
    output logic       mii_dv,
    output logic       mii_er,
    output logic [3:0] mii_data
);

    logic       dv_f;      // rising-edge sample of rx_ctl
    logic       err_f;     // falling-edge sample of rx_ctl
    logic       dv_ff;
    logic       err_ff;
    logic [3:0] rxd_f;
    logic [3:0] rxd_ff;

    // ------------------------------------------------------------------------
    // ddr capture of the control line
    // ------------------------------------------------------------------------
    always_ff @(posedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            dv_f <= 1'b0;
        end else begin
            dv_f <= rgmii_phy_rxctl;            // data valid half
        end
    end

    // second half of the cycle carries the xor-encoded error
    always_ff @(negedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            err_f <= 1'b0;
        end else begin
            err_f <= rgmii_phy_rxctl;
        end
    end

    // ------------------------------------------------------------------------
    // two rising-edge stages, data and control stay aligned
    // ------------------------------------------------------------------------
    always_ff @(posedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            rxd_f  <= '0;
            rxd_ff <= '0;
            dv_ff  <= 1'b0;
            err_ff <= 1'b0;
        end else begin
            rxd_f  <= rgmii_phy_rxd;
            rxd_ff <= rxd_f;
            dv_ff  <= dv_f;
            err_ff <= err_f;                    // picked up half a cycle after dv_f
        end
    end

    assign mii_dv   = dv_ff;
    assign mii_er   = dv_ff ^ err_ff;           // undo the rgmii xor encoding
    assign mii_data = rxd_ff;

endmodule

//--- mii_rx_framer.sv
// MII receive framer
// finds preamble and delimiter, packs nibbles into bytes (low nibble first)
// and tags the final byte of each frame with last and error

`timescale 1ns/1ps

module mii_rx_framer (
    input  logic       net_phy_rx_clk,
    input  logic       rgmii_phy_rst_n,
    input  logic       mii_dv,
    input  logic       mii_er,
    input  logic [3:0] mii_data,
    output logic       push,          // one-cycle strobe, never back to back
    output logic [7:0] push_data,
    output logic       push_last,
    output logic       push_err
);
    import eth_rx_pkg::*;

    framer_state_e state;
    logic          half;         // low nibble captured, high nibble pending
    logic [3:0]    lo_nib;
    logic          have_held;    // a finished byte waits for its successor
    logic [7:0]    held_byte;
    logic          err_sticky;   // er seen in this frame, or odd nibble count
    logic          flush_pend;   // dv dropped, send held byte as last

    always_ff @(posedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            state      <= st_idle;
            half       <= 1'b0;
            have_held  <= 1'b0;
            err_sticky <= 1'b0;
            flush_pend <= 1'b0;
            push       <= 1'b0;
        end else begin
            push       <= 1'b0;           // strobe by default
            flush_pend <= 1'b0;

            // end of frame, one cycle after dv fell so pushes stay spaced
            if (flush_pend) begin
                push      <= 1'b1;
                push_data <= held_byte;
                push_last <= 1'b1;
                push_err  <= err_sticky;
                have_held <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (mii_dv) begin
                        // first nibble must already be preamble
                        state <= (mii_data == preamble_nibble) ? st_preamble : st_drop;
                    end
                end

                st_preamble: begin
                    if (!mii_dv) begin
                        state <= st_idle;         // cut short, nothing pushed
                    end else if (mii_data == sfd_nibble) begin
                        state      <= st_data;
                        half       <= 1'b0;
                        have_held  <= 1'b0;
                        err_sticky <= 1'b0;       // fresh frame status
                    end else if (mii_data != preamble_nibble) begin
                        state <= st_drop;         // garbage where 5 or D belongs
                    end
                end

                st_data: begin
                    if (!mii_dv) begin
                        state      <= st_idle;
                        flush_pend <= have_held;  // no bytes, no push
                        err_sticky <= err_sticky | half;  // dangling nibble
                    end else begin
                        err_sticky <= err_sticky | mii_er;  // only data nibbles count
                        if (!half) begin
                            lo_nib <= mii_data;
                            half   <= 1'b1;
                        end else begin
                            half      <= 1'b0;
                            held_byte <= {mii_data, lo_nib};
                            have_held <= 1'b1;
                            // a new byte proves the held one is not last
                            if (have_held) begin
                                push      <= 1'b1;
                                push_data <= held_byte;
                                push_last <= 1'b0;
                                push_err  <= 1'b0;
                            end
                        end
                    end
                end

                st_drop: begin
                    if (!mii_dv) state <= st_idle;   // wait out the bad frame
                end

                default: state <= st_idle;
            endcase
        end
    end

    // fifo sizing relies on pushes being at least two cycles apart
    a_push_spaced: assert property (@(posedge net_phy_rx_clk) disable iff (!rgmii_phy_rst_n)
        push |=> !push)
        else $error("framer pushed on two consecutive cycles");

endmodule

//--- rx_byte_fifo.sv
// receive byte FIFO
// circular buffer of data bytes tagged with last and error, head shown combinationally

`timescale 1ns/1ps

module rx_byte_fifo (
    input  logic       net_phy_rx_clk,
    input  logic       rgmii_phy_rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       push_last,
    input  logic       push_err,
    input  logic       pop,
    output logic       not_empty,
    output logic [7:0] pop_data,
    output logic       pop_last,
    output logic       pop_err
);
    import eth_rx_pkg::*;

    localparam logic [fifo_addr_w:0] full_count = (fifo_addr_w + 1)'(fifo_depth);

    logic [9:0]             mem [fifo_depth];   // {err, last, data}
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;              // one extra bit to hold full
    logic                   full;

    assign full      = (count == full_count);
    assign not_empty = (count != '0);

    // storage, no reset needed
    always_ff @(posedge net_phy_rx_clk) begin
        if (push) mem[wr_ptr] <= {push_err, push_last, push_data};
    end

    // pointers and occupancy
    always_ff @(posedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

    // head of queue
    assign {pop_err, pop_last, pop_data} = mem[rd_ptr];

    // ------------------------------------------------------------------------
    // no back-pressure on either side, so both must hold by construction
    // ------------------------------------------------------------------------
    a_no_overflow: assert property (@(posedge net_phy_rx_clk) disable iff (!rgmii_phy_rst_n)
        push |-> !full)
        else $error("push into full rx fifo");

    a_no_underflow: assert property (@(posedge net_phy_rx_clk) disable iff (!rgmii_phy_rst_n)
        pop |-> not_empty)
        else $error("pop from empty rx fifo");

endmodule

//--- rx_frame_stats.sv
// receive frame statistics
// drains the byte FIFO every cycle, strobes bytes out and reports
// length and status at the last byte of each frame

`timescale 1ns/1ps

module rx_frame_stats (
    input  logic                              net_phy_rx_clk,
    input  logic                              rgmii_phy_rst_n,
    input  logic                              not_empty,
    input  logic [7:0]                        pop_data,
    input  logic                              pop_last,
    input  logic                              pop_err,
    output logic                              pop,
    output logic                              rx_byte_valid,
    output logic [7:0]                        rx_byte,
    output logic                              frame_done,
    output logic [eth_rx_pkg::frame_len_w-1:0] frame_len,
    output eth_rx_pkg::frame_status_e         frame_status
);
    import eth_rx_pkg::*;

    logic [frame_len_w-1:0] byte_cnt;   // bytes popped so far in this frame
    logic [frame_len_w-1:0] next_len;   // count including the byte at the head
    frame_status_e          status_nxt;

    // consumer never stalls
    assign pop = not_empty;

    assign next_len = byte_cnt + 1'b1;

    // ------------------------------------------------------------------------
    // status decode, error beats runt
    // ------------------------------------------------------------------------
    always_comb begin
        if (pop_err) begin
            status_nxt = fs_rx_error;
        end else if (next_len < min_frame_len) begin
            status_nxt = fs_runt;
        end else begin
            status_nxt = fs_good;
        end
    end

    // ------------------------------------------------------------------------
    // output strobes and running count
    // ------------------------------------------------------------------------
    always_ff @(posedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            rx_byte_valid <= 1'b0;
            frame_done    <= 1'b0;
            byte_cnt      <= '0;
        end else begin
            rx_byte_valid <= pop;                  // one edge after the pop
            frame_done    <= pop & pop_last;       // lines up with the last byte
            if (pop) begin
                if (pop_last) begin
                    byte_cnt <= '0;                // restart for next frame
                end else begin
                    byte_cnt <= next_len;
                end
            end
        end
    end

    // payload, only meaningful under its strobe
    always_ff @(posedge net_phy_rx_clk) begin
        if (pop) begin
            rx_byte <= pop_data;
        end
        if (pop && pop_last) begin
            frame_len    <= next_len;
            frame_status <= status_nxt;
        end
    end

endmodule

//--- eth_rx_top.sv
// RGMII Ethernet receive front end
// converter, framer, byte FIFO and frame statistics in one clock domain

`timescale 1ns/1ps

module eth_rx_top (
    input  logic                              net_phy_rx_clk,
    input  logic                              rgmii_phy_rst_n,
    input  logic                              rgmii_phy_rxctl,
    input  logic [3:0]                        rgmii_phy_rxd,
    output logic                              rx_byte_valid,
    output logic [7:0]                        rx_byte,
    output logic                              frame_done,
    output logic [eth_rx_pkg::frame_len_w-1:0] frame_len,
    output eth_rx_pkg::frame_status_e         frame_status
);

    // mii side
    logic       mii_dv;
    logic       mii_er;
    logic [3:0] mii_data;

    // framer to fifo
    logic       push;
    logic [7:0] push_data;
    logic       push_last;
    logic       push_err;

    // fifo to stats
    logic       not_empty;
    logic       pop;
    logic [7:0] pop_data;
    logic       pop_last;
    logic       pop_err;

    // ------------------------------------------------------------------------
    // datapath chain
    // ------------------------------------------------------------------------
    rgmii_rx_conv rgmii_rx_conv_inst (
        .net_phy_rx_clk, .rgmii_phy_rst_n, .rgmii_phy_rxctl, .rgmii_phy_rxd,
        .mii_dv, .mii_er, .mii_data
    );

    mii_rx_framer mii_rx_framer_inst (
        .net_phy_rx_clk, .rgmii_phy_rst_n, .mii_dv, .mii_er, .mii_data,
        .push, .push_data, .push_last, .push_err
    );

    rx_byte_fifo rx_byte_fifo_inst (
        .net_phy_rx_clk, .rgmii_phy_rst_n, .push, .push_data, .push_last, .push_err,
        .pop, .not_empty, .pop_data, .pop_last, .pop_err
    );

    rx_frame_stats rx_frame_stats_inst (
        .net_phy_rx_clk, .rgmii_phy_rst_n, .not_empty, .pop_data, .pop_last, .pop_err,
        .pop, .rx_byte_valid, .rx_byte, .frame_done, .frame_len, .frame_status
    );

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset source
// 40 ns receive clock, reset held low for the first 16 rising edges

`timescale 1ns/1ps

module tb_clk_gen (
    output logic net_phy_rx_clk,
    output logic rgmii_phy_rst_n
);

    localparam int half_period = 20;    // ns, 25 MHz rgmii rx clock
    localparam int rst_cycles  = 16;

    initial begin
        net_phy_rx_clk = 1'b0;
        forever #(half_period) net_phy_rx_clk = ~net_phy_rx_clk;
    end

    // release on a rising edge like every other driven input
    initial begin
        rgmii_phy_rst_n = 1'b0;
        repeat (rst_cycles) @(posedge net_phy_rx_clk);
        rgmii_phy_rst_n <= 1'b1;
    end

endmodule

//--- tb_checker.sv
// receive path checker
// rebuilds expected bytes and frame reports from the RGMII pins
// and compares them with the DUT strobes

`timescale 1ns/1ps

module tb_checker (
    input  logic                               net_phy_rx_clk,
    input  logic                               rgmii_phy_rst_n,
    input  logic                               rgmii_phy_rxctl,
    input  logic [3:0]                         rgmii_phy_rxd,
    input  logic                               rx_byte_valid,
    input  logic [7:0]                         rx_byte,
    input  logic                               frame_done,
    input  logic [eth_rx_pkg::frame_len_w-1:0] frame_len,
    input  eth_rx_pkg::frame_status_e          frame_status,
    input  logic                               end_run,
    output int                                 err_count,
    output int                                 pending,      // expected items not yet seen
    output logic                               summary_done
);
    import eth_rx_pkg::*;

    localparam int ph_idle = 0;   // line quiet
    localparam int ph_pre  = 1;   // inside preamble
    localparam int ph_data = 2;   // after the delimiter
    localparam int ph_skip = 3;   // broken preamble, ignore until dv drops

    int                     phase;
    logic                   fall_ctl;      // rx_ctl at the falling edge, dv ^ er
    logic                   pin_dv;        // nibble taken at the last rising edge
    logic [3:0]             pin_d;
    logic [3:0]             lo_nib;
    int                     data_nibs;
    logic                   frame_err;
    logic [frame_len_w-1:0] frame_bytes;
    logic [frame_len_w-1:0] out_bytes;     // bytes seen since the last frame_done
    logic [7:0]             exp_b;
    logic [frame_len_w-1:0] exp_l;
    frame_status_e          exp_s;
    int                     bytes_checked;
    int                     frames_checked;
    int                     n_good;
    int                     n_runt;
    int                     n_err;

    logic [7:0]             exp_bytes[$];
    logic [frame_len_w-1:0] exp_lens[$];
    frame_status_e          exp_stats[$];

    // status rule, error first, then the 64 byte minimum
    function automatic frame_status_e expected_status(input logic err,
                                                      input logic [frame_len_w-1:0] len);
        if (err) return fs_rx_error;
        if (len < 16'd64) return fs_runt;
        return fs_good;
    endfunction

    task automatic report_mismatch(input string sig, input int exp_v, input int got_v);
        $display("FAILED t=%0t %s expected %0h got %0h", $time, sig, exp_v, got_v);
        err_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("error at t=%0t: %s", $time, msg);
        err_count++;
    endtask

    // ------------------------------------------------------------------------
    // frame model, one nibble per call
    // ------------------------------------------------------------------------
    task automatic model_nibble(input logic dv, input logic er, input logic [3:0] d);
        case (phase)
            ph_idle: if (dv) phase = (d == 4'h5) ? ph_pre : ph_skip;
            ph_pre: begin
                if (!dv) phase = ph_idle;                 // cut short, nothing expected
                else if (d == 4'hd) begin
                    phase       = ph_data;
                    data_nibs   = 0;
                    frame_err   = 1'b0;
                    frame_bytes = '0;
                end else if (d != 4'h5) phase = ph_skip;
            end
            ph_data: begin
                if (!dv) begin
                    // report only when at least one whole byte came in
                    if (frame_bytes != '0) begin
                        exp_lens.push_back(frame_bytes);
                        exp_stats.push_back(expected_status(frame_err | data_nibs[0],
                                                            frame_bytes));
                    end
                    phase = ph_idle;
                end else begin
                    frame_err = frame_err | er;
                    if (data_nibs[0] == 1'b0) lo_nib = d;   // low nibble first
                    else begin
                        exp_bytes.push_back({d, lo_nib});
                        frame_bytes++;
                    end
                    data_nibs++;
                end
            end
            default: if (!dv) phase = ph_idle;
        endcase
    endtask

    always @(negedge net_phy_rx_clk) fall_ctl <= rgmii_phy_rxctl;

    always @(posedge net_phy_rx_clk) begin
        if (!rgmii_phy_rst_n) begin
            phase          = ph_idle;
            pin_dv         = 1'b0;
            pin_d          = 4'h0;
            out_bytes      = '0;
            err_count      = 0;
            pending        = 0;
            summary_done   = 1'b0;
            bytes_checked  = 0;
            frames_checked = 0;
            n_good         = 0;
            n_runt         = 0;
            n_err          = 0;
        end else begin
            // finish the nibble from the previous edge, its error half is now known
            model_nibble(pin_dv, pin_dv ^ fall_ctl, pin_d);
            pin_dv = rgmii_phy_rxctl;
            pin_d  = rgmii_phy_rxd;

            if (rx_byte_valid) begin
                out_bytes++;
                if (exp_bytes.size() == 0) report_problem("byte strobe with no byte expected");
                else begin
                    exp_b = exp_bytes.pop_front();
                    if (rx_byte !== exp_b) report_mismatch("rx_byte", exp_b, rx_byte);
                    bytes_checked++;
                end
            end

            if (frame_done) begin
                if (!rx_byte_valid) report_problem("frame_done without its last byte");
                if (exp_lens.size() == 0) report_problem("frame_done with no frame expected");
                else begin
                    exp_l = exp_lens.pop_front();
                    exp_s = exp_stats.pop_front();
                    if (frame_len !== exp_l) report_mismatch("frame_len", exp_l, frame_len);
                    if (out_bytes !== exp_l) report_mismatch("frame_done position", exp_l,
                                                             out_bytes);
                    if (frame_status !== exp_s) begin
                        $display("FAILED t=%0t frame_status expected %s got %s", $time,
                                 exp_s.name(), frame_status.name());
                        err_count++;
                    end
                    case (exp_s)
                        fs_good:     n_good++;
                        fs_runt:     n_runt++;
                        default:     n_err++;
                    endcase
                    frames_checked++;
                end
                out_bytes = '0;
            end

            pending = exp_bytes.size() + exp_lens.size();

            // leftovers and the closing count line
            if (end_run && !summary_done) begin
                if (exp_bytes.size() != 0) report_problem("expected bytes never came out");
                if (exp_lens.size() != 0) report_problem("expected frame reports never came");
                $display("summary: %0d bytes, %0d frames (%0d good, %0d runt, %0d error), %0d errors",
                         bytes_checked, frames_checked, n_good, n_runt, n_err, err_count);
                summary_done = 1'b1;
            end
        end
    end

endmodule

//--- tb_top.sv
// receive front end testbench top
// random RGMII frames from a Galois LFSR, DUT, checker and run timeout

`timescale 1ns/1ps

module tb_top;
    import eth_rx_pkg::*;

    // ------------------------------------------------------------------------
    // run length and a timeout sized from the longest possible frame
    // ------------------------------------------------------------------------
    localparam int num_frames   = 40;
    localparam int gap_max      = 9;
    localparam int pre_max      = 14;
    localparam int bytes_max    = 90;
    localparam int frame_cycles = gap_max + pre_max + 1 + 2 * bytes_max + 1;   // 205
    localparam int cycle_limit  = num_frames * frame_cycles + 200;

    logic                   net_phy_rx_clk;
    logic                   rgmii_phy_rst_n;
    logic                   rgmii_phy_rxctl;
    logic [3:0]             rgmii_phy_rxd;
    logic                   rx_byte_valid;
    logic [7:0]             rx_byte;
    logic                   frame_done;
    logic [frame_len_w-1:0] frame_len;
    frame_status_e          frame_status;

    logic                   end_run;
    int                     err_count;
    int                     pending;
    logic                   summary_done;
    int                     cycle_cnt = 0;
    logic [31:0]            lfsr_state;
    logic                   last_dv;      // nibble on the pins whose xor half goes out next
    logic                   last_er;

    tb_clk_gen clk_gen_inst (.net_phy_rx_clk, .rgmii_phy_rst_n);

    eth_rx_top eth_rx_top_inst (
        .net_phy_rx_clk, .rgmii_phy_rst_n, .rgmii_phy_rxctl, .rgmii_phy_rxd,
        .rx_byte_valid, .rx_byte, .frame_done, .frame_len, .frame_status
    );

    tb_checker checker_inst (
        .net_phy_rx_clk, .rgmii_phy_rst_n, .rgmii_phy_rxctl, .rgmii_phy_rxd,
        .rx_byte_valid, .rx_byte, .frame_done, .frame_len, .frame_status,
        .end_run, .err_count, .pending, .summary_done
    );

    // right shifting galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // one step per bit
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    // rising half carries dv, falling half dv ^ er, so the xor of a nibble
    // lands on the line at the edge after the one that samples its dv
    task automatic drive_nibble(input logic dv, input logic er, input logic [3:0] d);
        @(posedge net_phy_rx_clk);
        rgmii_phy_rxctl <= last_dv ^ last_er;
        rgmii_phy_rxd   <= d;
        @(negedge net_phy_rx_clk);
        rgmii_phy_rxctl <= dv;
        last_dv = dv;
        last_er = er;
    endtask

    task automatic send_frame();
        int         gap;
        int         pre_len;
        int         kind;
        int         nbytes;
        int         err_pos;
        logic       inj;
        logic [3:0] nib;
        logic [7:0] b;
        gap     = 2 + take_bits(3);                     // 2..9
        pre_len = 7 + take_bits(3);                     // 7..14
        kind    = take_bits(4);
        nbytes  = 1 + (take_bits(7) % bytes_max);       // 1..90
        inj     = (take_bits(3) == 0);
        err_pos = take_bits(8) % (2 * nbytes);
        repeat (gap) drive_nibble(1'b0, 1'b0, 4'h0);
        if (kind < 2) begin
            // dv drops somewhere inside the preamble
            repeat (1 + (take_bits(4) % pre_len)) drive_nibble(1'b1, 1'b0, preamble_nibble);
        end else begin
            repeat (pre_len) drive_nibble(1'b1, 1'b0, preamble_nibble);
            if (kind == 2) begin
                nib = 4'(take_bits(4));                 // wrong delimiter
                if (nib == preamble_nibble || nib == sfd_nibble) nib = 4'h0;
                drive_nibble(1'b1, 1'b0, nib);
            end else begin
                drive_nibble(1'b1, 1'b0, sfd_nibble);
            end
            for (int i = 0; i < nbytes; i++) begin
                b = 8'(take_bits(8));
                drive_nibble(1'b1, inj && (err_pos == 2 * i), b[3:0]);
                drive_nibble(1'b1, inj && (err_pos == 2 * i + 1), b[7:4]);
            end
            if (kind == 3 || kind == 4) begin
                // odd nibble left over at the end marks the frame as errored
                drive_nibble(1'b1, 1'b0, 4'(take_bits(4)));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        rgmii_phy_rxctl = 1'b0;
        rgmii_phy_rxd   = 4'h0;
        end_run         = 1'b0;
        last_dv         = 1'b0;
        last_er         = 1'b0;
        lfsr_state      = 32'd72250;
        wait (rgmii_phy_rst_n === 1'b1);
        for (int f = 0; f < num_frames; f++) send_frame();
        repeat (4) drive_nibble(1'b0, 1'b0, 4'h0);     // let the last frame end
        wait (pending == 0);                            // all expected items drained
        @(posedge net_phy_rx_clk);
        end_run <= 1'b1;
        wait (summary_done === 1'b1);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // run limit
    always @(posedge net_phy_rx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

//--- tb.f
eth_rx_pkg.sv
rgmii_rx_conv.sv
mii_rx_framer.sv
rx_byte_fifo.sv
rx_frame_stats.sv
eth_rx_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

//--- Makefile
# Verilator build and run for the RGMII receive front end

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
